// File: hw/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data path and pc width
`define XLEN 32

// register index width, 32 registers
`define REG_AW 5

// data RAM depth in words, indexed by byte address bits 9:2
`define DMEM_WORDS 256

// sequential fetch step in bytes
`define PC_STEP 4

`define RESET_PC 32'h0000_0000

`endif

// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_lui    = 7'b0110111
  } opcode_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
  } instr_u;

  // alu funct3 values, shared by op and op_imm
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;
  localparam logic [2:0] f3_bge = 3'b101;

  localparam logic [2:0] f3_byte = 3'b000; // lb / sb
  localparam logic [2:0] f3_word = 3'b010; // lw / sw

  localparam logic [6:0] f7_alt = 7'b0100000; // sub, sra

endpackage

// File: hw/core_ctrl_pkg.sv
package core_ctrl_pkg;

  typedef enum logic [3:0] {
    alu_add      = 4'd0,
    alu_sub      = 4'd1,
    alu_sll      = 4'd2,
    alu_srl      = 4'd3,
    alu_sra      = 4'd4,
    alu_and      = 4'd5,
    alu_or       = 4'd6,
    alu_xor      = 4'd7,
    alu_pass_imm = 4'd8  // lui
  } alu_op_t;

  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_eq   = 3'd1,
    br_ne   = 3'd2,
    br_lt   = 3'd3,
    br_ge   = 3'd4
  } branch_t;

  typedef enum logic [2:0] {
    mem_none = 3'd0,
    mem_lw   = 3'd1,
    mem_lb   = 3'd2,
    mem_sw   = 3'd3,
    mem_sb   = 3'd4
  } mem_op_t;

endpackage

// File: hw/fetch_stage.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module fetch_stage (
  input  logic             clk,
  input  logic             rst,
  input  logic             stall,
  input  logic             take_branch,
  input  logic [`XLEN-1:0] branch_target,
  output logic [`XLEN-1:0] pc
);

  logic [`XLEN-1:0] pc_plus_step;
  logic [`XLEN-1:0] next_pc;

  assign pc_plus_step = pc + `XLEN'(`PC_STEP);

  always_comb begin
    if (stall) begin
      next_pc = pc; // data memory wait cycle
    end else if (take_branch) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc_plus_step;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module decode_stage
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  instr_u             instr,
  input  logic [`XLEN-1:0]   pc,
  output alu_op_t            alu_op,
  output logic               use_imm,
  output logic [`XLEN-1:0]   imm,
  output branch_t            branch,
  output logic [`XLEN-1:0]   branch_target,
  output mem_op_t            mem_op,
  output logic               reg_write,
  output logic [`REG_AW-1:0] rs1,
  output logic [`REG_AW-1:0] rs2,
  output logic [`REG_AW-1:0] rd
);

  logic [`XLEN-1:0] i_imm;
  logic [`XLEN-1:0] s_imm;
  logic [`XLEN-1:0] b_imm;
  logic [`XLEN-1:0] u_imm;

  // register fields sit at the same bits in every format
  assign rs1 = instr.r.rs1;
  assign rs2 = instr.r.rs2;
  assign rd  = instr.r.rd;

  assign i_imm = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign s_imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
  assign b_imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                  instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
  // upper immediate covers the i-view fields above rd
  assign u_imm = {instr.i.imm, instr.i.rs1, instr.i.funct3, 12'b0};

  assign branch_target = pc + b_imm;

  always_comb begin
    alu_op    = alu_add;
    use_imm   = 1'b0;
    imm       = '0;
    branch    = br_none;
    mem_op    = mem_none;
    reg_write = 1'b0;
    case (instr.r.opcode)
      opc_op: begin
        reg_write = 1'b1;
        case (instr.r.funct3)
          f3_add_sub: alu_op = (instr.r.funct7 == f7_alt) ? alu_sub : alu_add;
          f3_sll:     alu_op = alu_sll;
          f3_xor:     alu_op = alu_xor;
          f3_srl_sra: alu_op = (instr.r.funct7 == f7_alt) ? alu_sra : alu_srl;
          f3_or:      alu_op = alu_or;
          f3_and:     alu_op = alu_and;
          default:    reg_write = 1'b0; // slt, sltu
        endcase
      end
      opc_op_imm: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        imm       = i_imm;
        case (instr.i.funct3)
          f3_add_sub: alu_op = alu_add;
          f3_sll:     alu_op = alu_sll;
          f3_xor:     alu_op = alu_xor;
          f3_srl_sra: alu_op = instr.i.imm[10] ? alu_sra : alu_srl;
          f3_or:      alu_op = alu_or;
          f3_and:     alu_op = alu_and;
          default:    reg_write = 1'b0;
        endcase
      end
      opc_load: begin
        use_imm = 1'b1;
        imm     = i_imm;
        if (instr.i.funct3 == f3_word) begin
          mem_op    = mem_lw;
          reg_write = 1'b1;
        end else if (instr.i.funct3 == f3_byte) begin
          mem_op    = mem_lb;
          reg_write = 1'b1;
        end
      end
      opc_store: begin
        use_imm = 1'b1;
        imm     = s_imm;
        if (instr.s.funct3 == f3_word) begin
          mem_op = mem_sw;
        end else if (instr.s.funct3 == f3_byte) begin
          mem_op = mem_sb;
        end
      end
      opc_branch: begin
        alu_op = alu_sub; // compare via rs1 - rs2
        case (instr.b.funct3)
          f3_beq:  branch = br_eq;
          f3_bne:  branch = br_ne;
          f3_blt:  branch = br_lt;
          f3_bge:  branch = br_ge;
          default: branch = br_none;
        endcase
      end
      opc_lui: begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        imm       = u_imm;
        alu_op    = alu_pass_imm;
      end
      default: ;
    endcase
  end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  logic [`REG_AW-1:0] rs1,
  input  logic [`REG_AW-1:0] rs2,
  output logic [`XLEN-1:0]   rs1_data,
  output logic [`XLEN-1:0]   rs2_data,
  input  logic               wb_en,
  input  logic [`REG_AW-1:0] wb_rd,
  input  logic [`XLEN-1:0]   wb_data
);

  localparam int num_regs = 1 << `REG_AW;

  logic [`XLEN-1:0] regs [num_regs];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_rd != '0) begin // x0 stays zero
      regs[wb_rd] <= wb_data;
    end
  end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module execute_stage
  import core_ctrl_pkg::*;
(
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  input  logic [`XLEN-1:0] imm,
  input  logic             use_imm,
  input  alu_op_t          alu_op,
  input  branch_t          branch,
  output logic [`XLEN-1:0] alu_result,
  output logic             take_branch
);

  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;
  logic             zero;
  logic             neg;
  logic             ovf;

  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0]; // low five bits only

  always_comb begin
    case (alu_op)
      alu_add:      alu_result = rs1_data + op_b;
      alu_sub:      alu_result = rs1_data - op_b;
      alu_sll:      alu_result = rs1_data << shamt;
      alu_srl:      alu_result = rs1_data >> shamt;
      alu_sra:      alu_result = $signed(rs1_data) >>> shamt;
      alu_and:      alu_result = rs1_data & op_b;
      alu_or:       alu_result = rs1_data | op_b;
      alu_xor:      alu_result = rs1_data ^ op_b;
      alu_pass_imm: alu_result = imm;
      default:      alu_result = '0;
    endcase
  end

  assign zero = (alu_result == '0);
  assign neg  = alu_result[`XLEN-1];

  // signed overflow of add or sub, else clear
  always_comb begin
    ovf = 1'b0;
    if (alu_op == alu_add) begin
      ovf = (rs1_data[`XLEN-1] == op_b[`XLEN-1]) && (neg != rs1_data[`XLEN-1]);
    end else if (alu_op == alu_sub) begin
      ovf = (rs1_data[`XLEN-1] != op_b[`XLEN-1]) && (neg != rs1_data[`XLEN-1]);
    end
  end

  always_comb begin
    case (branch)
      br_eq:   take_branch = zero;
      br_ne:   take_branch = !zero;
      br_lt:   take_branch = neg ^ ovf;
      br_ge:   take_branch = !(neg ^ ovf);
      default: take_branch = 1'b0;
    endcase
  end

endmodule

// File: hw/memory_stage.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module memory_stage
  import core_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  mem_op_t            mem_op,
  input  logic               reg_write,
  input  logic [`REG_AW-1:0] rd,
  input  logic [`XLEN-1:0]   alu_result,
  input  logic [`XLEN-1:0]   rs2_data,
  output logic               stall,
  output logic               retire,
  output logic               wb_en,
  output logic [`REG_AW-1:0] wb_rd,
  output logic [`XLEN-1:0]   wb_data
);

  localparam int dmem_aw = $clog2(`DMEM_WORDS);

  typedef enum logic {st_idle, st_wait} state_t;

  state_t             state;
  logic [`XLEN-1:0]   ram [`DMEM_WORDS];
  logic [dmem_aw-1:0] word_idx;
  logic [`XLEN-1:0]   store_data;
  logic [`XLEN-1:0]   load_word;
  logic               is_mem;

  assign is_mem   = (mem_op != mem_none);
  assign word_idx = alu_result[dmem_aw+1:2];
  assign stall    = (state == st_idle) && is_mem;

  // sb stores the zero-extended low byte as a full word
  assign store_data = (mem_op == mem_sb) ? {{(`XLEN-8){1'b0}}, rs2_data[7:0]} : rs2_data;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_idle;
    end else if (state == st_idle) begin
      state <= is_mem ? st_wait : st_idle;
    end else begin
      state <= st_idle;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `DMEM_WORDS; i++) begin
        ram[i] <= '0;
      end
    end else if (stall && (mem_op == mem_sw || mem_op == mem_sb)) begin
      ram[word_idx] <= store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (stall) begin
      load_word <= ram[word_idx]; // captured in the first cycle
    end
  end

  always_comb begin
    case (mem_op)
      mem_lw:  wb_data = load_word;
      mem_lb:  wb_data = {{(`XLEN-8){1'b0}}, load_word[7:0]};
      default: wb_data = alu_result;
    endcase
  end

  assign retire = (state == st_wait) || !is_mem;
  assign wb_en  = reg_write && retire;
  assign wb_rd  = rd;

endmodule

// File: hw/rv_core_top.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module rv_core_top
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  output logic [`XLEN-1:0]   imem_addr,
  input  logic [`XLEN-1:0]   instr,
  output logic               retire,
  output logic               wb_en,
  output logic [`REG_AW-1:0] wb_rd,
  output logic [`XLEN-1:0]   wb_data
);

  logic [`XLEN-1:0]   pc;
  instr_u             instr_word;
  alu_op_t            alu_op;
  logic               use_imm;
  logic [`XLEN-1:0]   imm;
  branch_t            branch;
  logic [`XLEN-1:0]   branch_target;
  mem_op_t            mem_op;
  logic               reg_write;
  logic [`REG_AW-1:0] rs1;
  logic [`REG_AW-1:0] rs2;
  logic [`REG_AW-1:0] rd;
  logic [`XLEN-1:0]   rs1_data;
  logic [`XLEN-1:0]   rs2_data;
  logic [`XLEN-1:0]   alu_result;
  logic               take_branch;
  logic               stall;

  assign imem_addr  = pc;
  assign instr_word = instr;

  fetch_stage fetch0 (
    .clk           (clk),
    .rst           (rst),
    .stall         (stall),
    .take_branch   (take_branch),
    .branch_target (branch_target),
    .pc            (pc)
  );

  decode_stage decode0 (
    .instr         (instr_word),
    .pc            (pc),
    .alu_op        (alu_op),
    .use_imm       (use_imm),
    .imm           (imm),
    .branch        (branch),
    .branch_target (branch_target),
    .mem_op        (mem_op),
    .reg_write     (reg_write),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd)
  );

  reg_file regs0 (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  execute_stage execute0 (
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .use_imm     (use_imm),
    .alu_op      (alu_op),
    .branch      (branch),
    .alu_result  (alu_result),
    .take_branch (take_branch)
  );

  memory_stage memory0 (
    .clk        (clk),
    .rst        (rst),
    .mem_op     (mem_op),
    .reg_write  (reg_write),
    .rd         (rd),
    .alu_result (alu_result),
    .rs2_data   (rs2_data),
    .stall      (stall),
    .retire     (retire),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

endmodule

// File: tests/rv_core_properties.sv
`timescale 1ns/1ns

module rv_core_properties
  import core_ctrl_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input mem_op_t mem_op,
  input logic    fsm_wait,
  input logic    stall,
  input logic    retire
);

  logic is_mem;

  assign is_mem = (mem_op != mem_none);

  // held pc keeps the same load or store in front of the wait cycle
  mem_first_cycle: assert property (@(posedge clk) disable iff (rst)
    (is_mem && !fsm_wait) |=> $stable(mem_op))
    else begin
      $error("load or store changed before its wait cycle");
      rv_core_tb.assert_fails = rv_core_tb.assert_fails + 1;
    end

  mem_one_wait: assert property (@(posedge clk) disable iff (rst)
    stall |=> (fsm_wait && retire && !stall))
    else begin
      $error("load or store did not retire after one wait cycle");
      rv_core_tb.assert_fails = rv_core_tb.assert_fails + 1;
    end

  // every retire leaves the FSM idle for the next instruction
  retire_to_idle: assert property (@(posedge clk) disable iff (rst)
    retire |=> !fsm_wait)
    else begin
      $error("FSM stayed in its wait state after a retire");
      rv_core_tb.assert_fails = rv_core_tb.assert_fails + 1;
    end

  reset_idle: assert property (@(posedge clk) rst |=> !fsm_wait)
    else begin
      $error("FSM left idle during reset");
      rv_core_tb.assert_fails = rv_core_tb.assert_fails + 1;
    end

endmodule

// File: tests/rv_core_tb.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module rv_core_tb
  import rv_isa_pkg::*;
();

  localparam int prog_words  = 64;
  localparam int cycle_limit = 2 * prog_words * 2 + 20; // two cycles per word, twice over

  localparam logic [2:0] alu_f3 [8] = '{f3_add_sub, f3_add_sub, f3_sll, f3_srl_sra,
                                        f3_srl_sra, f3_xor, f3_or, f3_and};
  localparam logic [6:0] alu_f7 [8] = '{7'h00, f7_alt, 7'h00, 7'h00, f7_alt, 7'h00, 7'h00, 7'h00};
  localparam logic [2:0] br_f3  [4] = '{f3_beq, f3_bne, f3_blt, f3_bge};

  logic               clk;
  logic               rst;
  logic [`XLEN-1:0]   instr;
  logic [`XLEN-1:0]   imem_addr;
  logic               retire;
  logic               wb_en;
  logic [`REG_AW-1:0] wb_rd;
  logic [`XLEN-1:0]   wb_data;

  logic [`XLEN-1:0]   imem [prog_words];
  logic [`XLEN-1:0]   model_regs [32];
  logic [`XLEN-1:0]   model_mem [`DMEM_WORDS];
  integer             seed;

  int error_count  = 0;
  int check_count  = 0;
  int assert_fails = 0; // raised by the bound properties
  int cycle_count  = 0;
  int retired      = 0;
  logic done       = 1'b0;
  logic timed_out  = 1'b0;
  logic held       = 1'b0;

  logic [`XLEN-1:0]   exp_pc;
  logic [`XLEN-1:0]   cur;
  logic               exp_we;
  logic [`REG_AW-1:0] exp_rd;
  logic [`XLEN-1:0]   exp_data;
  logic [`XLEN-1:0]   next_pc;

  rv_core_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .instr     (instr),
    .retire    (retire),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % $unsigned(n));
  endfunction

  function automatic logic [`XLEN-1:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [`XLEN-1:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [`XLEN-1:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic logic [`XLEN-1:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic logic [`XLEN-1:0] u_word(input logic [19:0] upper, input logic [4:0] rd);
    return {upper, rd, opc_lui};
  endfunction

  function automatic logic [`XLEN-1:0] alu_value(input logic [2:0] f3, input logic alt,
      input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] result;
    result = '0;
    case (f3)
      f3_add_sub: result = alt ? a - b : a + b;
      f3_sll:     result = a << b[4:0];
      f3_xor:     result = a ^ b;
      f3_srl_sra: begin
        if (alt) begin
          result = $signed(a) >>> b[4:0];
        end else begin
          result = a >> b[4:0];
        end
      end
      f3_or:      result = a | b;
      f3_and:     result = a & b;
      default:    result = '0;
    endcase
    return result;
  endfunction

  // one instruction on the model state: expected write and next pc
  function automatic void predict_instr(input logic [`XLEN-1:0] pc,
      input logic [`XLEN-1:0] ins, output logic we, output logic [`REG_AW-1:0] rd,
      output logic [`XLEN-1:0] val, output logic [`XLEN-1:0] npc);
    logic [2:0]       f3;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] i_imm;
    logic [`XLEN-1:0] s_imm;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] addr;
    logic [7:0]       idx;
    logic             taken;
    f3    = ins[14:12];
    rd    = ins[11:7];
    a     = model_regs[ins[19:15]];
    b     = model_regs[ins[24:20]];
    i_imm = {{20{ins[31]}}, ins[31:20]};
    s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    b_imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    we    = 1'b0;
    val   = '0;
    taken = 1'b0;
    npc   = pc + `PC_STEP;
    case (ins[6:0])
      opc_op: begin
        we  = 1'b1;
        val = alu_value(f3, ins[30], a, b);
      end
      opc_op_imm: begin
        we  = 1'b1;
        val = alu_value(f3, (f3 == f3_srl_sra) && ins[30], a, i_imm); // no subi
      end
      opc_lui: begin
        we  = 1'b1;
        val = {ins[31:12], 12'b0};
      end
      opc_load: begin
        we   = 1'b1;
        addr = a + i_imm;
        idx  = addr[9:2];
        val  = (f3 == f3_word) ? model_mem[idx] : {{(`XLEN-8){1'b0}}, model_mem[idx][7:0]};
      end
      opc_store: begin
        addr = a + s_imm;
        idx  = addr[9:2];
        model_mem[idx] = (f3 == f3_byte) ? {{(`XLEN-8){1'b0}}, b[7:0]} : b;
      end
      opc_branch: begin
        case (f3)
          f3_beq:  taken = (a == b);
          f3_bne:  taken = (a != b);
          f3_blt:  taken = ($signed(a) < $signed(b));
          f3_bge:  taken = ($signed(a) >= $signed(b));
          default: taken = 1'b0;
        endcase
        if (taken) begin
          npc = pc + b_imm;
        end
      end
      default: ;
    endcase
    if (we && rd != '0) begin
      model_regs[rd] = val;
    end
  endfunction

  task automatic build_program();
    int                 k;
    int                 sel;
    int                 op;
    logic [`REG_AW-1:0] rd;
    logic [`REG_AW-1:0] s1;
    logic [`REG_AW-1:0] s2;
    logic [11:0]        mem_imm;
    logic [11:0]        imm;
    for (int i = 0; i < 8; i++) begin
      imem[i] = u_word(20'($random(seed)), 5'(i + 1));
    end
    imem[0] = u_word(20'h80000, 5'd1); // x1 most negative
    imem[1] = u_word(20'h7ffff, 5'd2); // x2 large positive
    for (int i = 8; i < 16; i++) begin
      imem[i] = i_word(12'($random(seed)), 5'(i - 7), f3_add_sub, 5'(i - 7), opc_op_imm);
    end
    imem[8] = i_word(12'h000, 5'd1, f3_add_sub, 5'd1, opc_op_imm);
    for (int i = 16; i < prog_words - 1; i++) begin
      rd  = 5'(rand_below(16));
      s1  = 5'(rand_below(16));
      s2  = 5'(rand_below(16));
      op  = rand_below(8);
      sel = rand_below(10);
      k   = 1 + rand_below((prog_words - 1 - i) < 4 ? (prog_words - 1 - i) : 4);
      // bit 10 aliases onto the same word
      mem_imm = {1'b0, 1'(rand_below(2)), 4'b0, 4'(rand_below(16)), 2'b00};
      if (i == 16) begin
        imem[i] = b_word(13'd8, 5'd2, 5'd1, f3_blt); // x1 - x2 overflows
      end else if (i == 18) begin
        imem[i] = b_word(13'd8, 5'd1, 5'd2, f3_bge);
      end else begin
        case (sel)
          0, 1, 2: imem[i] = r_word(alu_f7[op], s2, s1, alu_f3[op], rd);
          3, 4: begin
            if (op == 1) begin
              op = 0;
            end
            if (alu_f3[op] == f3_sll || alu_f3[op] == f3_srl_sra) begin
              imm = {alu_f7[op], 5'(rand_below(32))};
            end else begin
              imm = 12'($random(seed));
            end
            imem[i] = i_word(imm, s1, alu_f3[op], rd, opc_op_imm);
          end
          5: imem[i] = u_word(20'($random(seed)), rd);
          6: imem[i] = s_word(mem_imm, s2, 5'd0, (rand_below(2) != 0) ? f3_word : f3_byte);
          7: imem[i] = i_word(mem_imm, 5'd0, (rand_below(2) != 0) ? f3_word : f3_byte, rd,
                              opc_load);
          default: imem[i] = b_word(13'(k * 4), s2, s1, br_f3[rand_below(4)]);
        endcase
      end
    end
    imem[prog_words - 1] = b_word(13'd0, 5'd0, 5'd0, f3_beq); // self-loop
  endtask

  task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
      input logic [`XLEN-1:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[ERROR] %0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input logic [`REG_AW-1:0] exp,
      input logic [`REG_AW-1:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[ERROR] %0t %s expected x%0d actual x%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // compare at every rising edge, outputs settled since the falling edge
  always @(posedge clk) begin
    if (!rst && !done) begin
      cycle_count++;
      cur = imem[exp_pc[7:2]];
      check_word("imem_addr", exp_pc, imem_addr);
      if (retire) begin
        if ((cur[6:0] == opc_load || cur[6:0] == opc_store) && !held) begin
          error_count++;
          $display("load or store at pc 0x%08h retired without its wait cycle", exp_pc);
        end
        predict_instr(exp_pc, cur, exp_we, exp_rd, exp_data, next_pc);
        check_flag("wb_en", exp_we, wb_en);
        if (exp_we) begin
          check_reg("wb_rd", exp_rd, wb_rd);
          check_word("wb_data", exp_data, wb_data);
        end
        if (next_pc == exp_pc) begin
          done = 1'b1;
        end
        exp_pc = next_pc;
        held   = 1'b0;
        retired++;
      end else begin
        check_flag("wb_en", 1'b0, wb_en);
        if (cur[6:0] != opc_load && cur[6:0] != opc_store) begin
          error_count++;
          $display("instruction 0x%08h at pc 0x%08h did not retire in one cycle", cur, exp_pc);
        end
        if (held) begin
          error_count++;
          $display("pc 0x%08h held for more than one wait cycle", exp_pc);
        end
        held = 1'b1;
      end
      if (!done && cycle_count >= cycle_limit) begin
        timed_out = 1'b1;
        done      = 1'b1;
      end
    end
  end

  initial begin
    rst    = 1'b1;
    seed   = 32'ha953;
    exp_pc = `RESET_PC;
    instr  = i_word(12'h000, 5'd0, f3_word, 5'd0, opc_load); // idle FSM keeps retire low
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      model_mem[i] = '0;
    end
    build_program();
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_flag("retire", 1'b0, retire);
    check_flag("wb_en", 1'b0, wb_en);
    check_word("imem_addr", `RESET_PC, imem_addr);
    rst   = 1'b0;
    instr = imem[imem_addr[7:2]];
    while (!done) begin
      @(negedge clk);
      instr = imem[imem_addr[7:2]];
    end
    if (timed_out) begin
      $display("timeout: self-loop not reached within %0d cycles", cycle_limit);
    end
    $display("checks %0d, errors %0d, assertion failures %0d, retired %0d",
             check_count, error_count, assert_fails, retired);
    if (error_count == 0 && assert_fails == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  bind memory_stage rv_core_properties props0 (
    .clk      (clk),
    .rst      (rst),
    .mem_op   (mem_op),
    .fsm_wait (state), // st_wait encodes as 1
    .stall    (stall),
    .retire   (retire)
  );

endmodule

// File: list.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/core_ctrl_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/rv_core_top.sv
tests/rv_core_properties.sv
tests/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module rv_core_tb \
  -f list.f \
  --Mdir "$build_dir" -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running past assertion errors so the testbench reports them
"./$build_dir/rv_core_sim" +verilator+error+limit+1000 > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$log_file"; then
  exit 1
fi
exit 0
